/* common/lane_cfg_pkg.sv */
// Sizes and address types of the single-bank lane.
// The VRF address is the register index on top of the element index,
// so MaxVl and NrVRegs must stay powers of two.

package lane_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned MaxVl     = 8;
  localparam int unsigned VrfDepth  = NrVRegs * MaxVl;
  localparam int unsigned IdWidth   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;

  // Register index
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // Element index inside one register
  typedef logic [$clog2(MaxVl)-1:0] eidx_t;

  // Vector length, 0 up to MaxVl inclusive
  typedef logic [$clog2(MaxVl+1)-1:0] vl_t;

  // Word address, {vreg_t, eidx_t}
  typedef logic [$clog2(VrfDepth)-1:0] vaddr_t;

  typedef logic [IdWidth-1:0] vid_t;

endpackage

/* common/lane_isa_pkg.sv */
// Instruction set of the lane and the structs that cross stage boundaries.
// Only integer element-wise ops and a whole-register store exist.

package lane_isa_pkg;

  // Opcodes
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } lane_op_e;

  // One instruction as issued to the lane
  // VSTORE streams out register vd, the arithmetic ops write vd
  typedef struct packed {
    lane_op_e            op;
    lane_cfg_pkg::vreg_t vd;
    lane_cfg_pkg::vreg_t vs1;
    lane_cfg_pkg::vreg_t vs2;
    lane_cfg_pkg::vl_t   vl;
    lane_cfg_pkg::vid_t  id;
  } lane_insn_t;

  // VRF write request, from the load port or the ALU
  typedef struct packed {
    lane_cfg_pkg::vaddr_t addr;
    lane_cfg_pkg::elem_t  wdata;
  } vrf_wreq_t;

  // Operand pair for the ALU
  typedef struct packed {
    lane_op_e             op;
    lane_cfg_pkg::elem_t  vs1_op;
    lane_cfg_pkg::elem_t  vs2_op;
    lane_cfg_pkg::vaddr_t addr;
  } alu_req_t;

endpackage

/* design/lane_alu.sv */
// Element-wise integer ALU, one registered stage.
// Arithmetic wraps; VSUB computes vs2 minus vs1.

module lane_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_isa_pkg::alu_req_t  req_i,
  input  logic                    valid_i,
  output lane_isa_pkg::vrf_wreq_t res_o,
  output logic                    res_valid_o
);

  lane_cfg_pkg::elem_t     result;
  lane_isa_pkg::vrf_wreq_t res_q;
  logic                    res_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      lane_isa_pkg::VADD: result = req_i.vs2_op + req_i.vs1_op;
      lane_isa_pkg::VSUB: result = req_i.vs2_op - req_i.vs1_op;
      lane_isa_pkg::VAND: result = req_i.vs2_op & req_i.vs1_op;
      lane_isa_pkg::VOR:  result = req_i.vs2_op | req_i.vs1_op;
      lane_isa_pkg::VXOR: result = req_i.vs2_op ^ req_i.vs1_op;
      // Stores never reach the ALU
      default:            result = req_i.vs2_op;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= valid_i;
    end
  end

  // Result travels with its destination word
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_q.addr  <= req_i.addr;
      res_q.wdata <= result;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

/* lane/vector_regfile.sv */
// Single-bank VRF, one read and one write per cycle.
// Read data is registered and holds while no read is enabled;
// a same-cycle read of a word being written returns the old value.

module vector_regfile (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Read port
  input  logic                    rd_en_i,
  input  lane_cfg_pkg::vaddr_t    rd_addr_i,
  output lane_cfg_pkg::elem_t     rd_data_o,
  // Write port
  input  logic                    wr_en_i,
  input  lane_isa_pkg::vrf_wreq_t wr_i
);

  lane_cfg_pkg::elem_t mem_q [lane_cfg_pkg::VrfDepth];
  lane_cfg_pkg::elem_t rd_data_q;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_i.addr] <= wr_i.wdata;
    end
  end

  // The store path relies on this register holding under stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_q <= '0;
    end else if (rd_en_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

/* lane/lane_sequencer.sv */
// Accepts one instruction at a time and holds it until the requester finishes.
// Ready reopens the cycle after the done pulse.

module lane_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction port
  input  lane_isa_pkg::lane_insn_t insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  // Requester command
  output lane_isa_pkg::lane_insn_t cmd_o,
  output logic                     cmd_start_o,
  input  logic                     cmd_finish_i,
  // Completion
  output logic                     done_o,
  output lane_cfg_pkg::vid_t       done_id_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } seq_state_e;

  seq_state_e               state_q, state_d;
  lane_isa_pkg::lane_insn_t cmd_q;
  logic                     start_q;
  logic                     accept;

  assign insn_ready_o = (state_q == IDLE);
  assign accept       = insn_valid_i & insn_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (cmd_finish_i) begin
          state_d = DONE;
        end
      end
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Start fires the cycle after acceptance
      start_q <= accept;
    end
  end

  // Held for the whole run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= insn_i;
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_start_o = start_q;
  assign done_o      = (state_q == DONE);
  assign done_id_o   = cmd_q.id;

endmodule

/* lane/operand_requester.sv */
// Issues VRF reads for the running instruction and arbitrates the write port.
// Arithmetic reads vs2 then vs1 per element; VSTORE reads vd once per element.
// ALU results win the write port over the load port.

module operand_requester (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer
  input  lane_isa_pkg::lane_insn_t cmd_i,
  input  logic                     cmd_start_i,
  output logic                     cmd_finish_o,
  // VRF
  output lane_cfg_pkg::vaddr_t     rd_addr_o,
  output logic                     rd_en_o,
  input  lane_cfg_pkg::elem_t      rd_data_i,
  output logic                     wr_en_o,
  output lane_isa_pkg::vrf_wreq_t  wr_o,
  // ALU
  output lane_isa_pkg::alu_req_t   alu_req_o,
  output logic                     alu_valid_o,
  input  lane_isa_pkg::vrf_wreq_t  alu_res_i,
  input  logic                     alu_res_valid_i,
  // Load port
  input  logic                     ldu_req_i,
  input  lane_isa_pkg::vrf_wreq_t  ldu_wreq_i,
  output logic                     ldu_gnt_o,
  // Store stream
  output lane_cfg_pkg::elem_t      stu_operand_o,
  output logic                     stu_valid_o,
  input  logic                     stu_ready_i
);

  logic                busy_q;
  logic                active;
  logic                is_store;
  logic                stall;
  logic                stu_load;
  logic                elem_done;
  // Issue side: next element and operand phase, 0 is vs2 and 1 is vs1
  lane_cfg_pkg::vl_t   idx_q;
  logic                phase_q;
  // Return side: what the VRF output currently holds
  logic                ret_vld_q;
  logic                ret_phase_q;
  lane_cfg_pkg::eidx_t ret_idx_q;
  lane_cfg_pkg::vl_t   done_cnt_q;
  lane_cfg_pkg::elem_t vs2_q;
  lane_cfg_pkg::elem_t stu_q;
  logic                stu_valid_q;

  assign is_store = (cmd_i.op == lane_isa_pkg::VSTORE);
  assign active   = cmd_start_i | busy_q;
  // Only the store output can hold up the pipe
  assign stall    = stu_valid_q & ~stu_ready_i;
  assign rd_en_o  = active & (idx_q < cmd_i.vl) & ~stall;

  always_comb begin
    if (is_store) begin
      rd_addr_o = {cmd_i.vd, lane_cfg_pkg::eidx_t'(idx_q)};
    end else if (phase_q) begin
      rd_addr_o = {cmd_i.vs1, lane_cfg_pkg::eidx_t'(idx_q)};
    end else begin
      rd_addr_o = {cmd_i.vs2, lane_cfg_pkg::eidx_t'(idx_q)};
    end
  end

  // Pair vs1 from the VRF output with the vs2 captured a cycle earlier
  assign alu_valid_o      = ret_vld_q & ret_phase_q & ~is_store;
  assign alu_req_o.op     = cmd_i.op;
  assign alu_req_o.vs1_op = rd_data_i;
  assign alu_req_o.vs2_op = vs2_q;
  assign alu_req_o.addr   = {cmd_i.vd, ret_idx_q};

  ////////////////////////////////////////////////////////////////////////////
  // Write port and completion
  ////////////////////////////////////////////////////////////////////////////

  assign ldu_gnt_o = ldu_req_i & ~alu_res_valid_i;
  assign wr_en_o   = alu_res_valid_i | ldu_req_i;
  assign wr_o      = alu_res_valid_i ? alu_res_i : ldu_wreq_i;

  assign stu_load  = ret_vld_q & is_store & ~stall;
  assign elem_done = busy_q & (is_store ? (stu_valid_q & stu_ready_i) : alu_res_valid_i);

  // A zero-length instruction finishes on its start pulse
  assign cmd_finish_o = (cmd_start_i & (cmd_i.vl == '0)) |
                        (elem_done & (lane_cfg_pkg::vl_t'(done_cnt_q + 1'b1) == cmd_i.vl));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      idx_q       <= '0;
      phase_q     <= 1'b0;
      ret_vld_q   <= 1'b0;
      ret_phase_q <= 1'b0;
      ret_idx_q   <= '0;
      done_cnt_q  <= '0;
      stu_valid_q <= 1'b0;
    end else begin
      if (cmd_finish_o) begin
        busy_q     <= 1'b0;
        idx_q      <= '0;
        phase_q    <= 1'b0;
        done_cnt_q <= '0;
      end else begin
        if (cmd_start_i) begin
          busy_q <= 1'b1;
        end
        if (rd_en_o) begin
          if (is_store || phase_q) begin
            idx_q   <= idx_q + 1'b1;
            phase_q <= 1'b0;
          end else begin
            phase_q <= 1'b1;
          end
        end
        if (elem_done) begin
          done_cnt_q <= done_cnt_q + 1'b1;
        end
      end
      // The VRF output holds while stalled, so its tags hold too
      if (!stall) begin
        ret_vld_q   <= rd_en_o;
        ret_phase_q <= phase_q;
        ret_idx_q   <= lane_cfg_pkg::eidx_t'(idx_q);
      end
      if (stu_load) begin
        stu_valid_q <= 1'b1;
      end else if (stu_ready_i) begin
        stu_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret_vld_q && !ret_phase_q) begin
      vs2_q <= rd_data_i;
    end
    if (stu_load) begin
      stu_q <= rd_data_i;
    end
  end

  assign stu_operand_o = stu_q;
  assign stu_valid_o   = stu_valid_q;

endmodule

/* lane/lane.sv */
// Vector lane top: sequencer, operand requester, VRF and ALU.
// One instruction runs at a time; only the store port has back-pressure.

module lane (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction port
  input  lane_isa_pkg::lane_insn_t insn_i,
  input  logic                    insn_valid_i,
  output logic                    insn_ready_o,
  // Load write port
  input  logic                    ldu_req_i,
  input  lane_isa_pkg::vrf_wreq_t ldu_wreq_i,
  output logic                    ldu_gnt_o,
  // Store stream
  output lane_cfg_pkg::elem_t     stu_operand_o,
  output logic                    stu_valid_o,
  input  logic                    stu_ready_i,
  // Completion
  output logic                    done_o,
  output lane_cfg_pkg::vid_t      done_id_o
);

  // Sequencer to requester
  lane_isa_pkg::lane_insn_t cmd;
  logic                     cmd_start;
  logic                     cmd_finish;

  // Requester to VRF
  lane_cfg_pkg::vaddr_t    rd_addr;
  logic                    rd_en;
  lane_cfg_pkg::elem_t     rd_data;
  logic                    wr_en;
  lane_isa_pkg::vrf_wreq_t wr;

  // Requester to ALU and back
  lane_isa_pkg::alu_req_t  alu_req;
  logic                    alu_valid;
  lane_isa_pkg::vrf_wreq_t alu_res;
  logic                    alu_res_valid;

  lane_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .cmd_o        (cmd),
    .cmd_start_o  (cmd_start),
    .cmd_finish_i (cmd_finish),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

  operand_requester u_requester (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd),
    .cmd_start_i     (cmd_start),
    .cmd_finish_o    (cmd_finish),
    .rd_addr_o       (rd_addr),
    .rd_en_o         (rd_en),
    .rd_data_i       (rd_data),
    .wr_en_o         (wr_en),
    .wr_o            (wr),
    .alu_req_o       (alu_req),
    .alu_valid_o     (alu_valid),
    .alu_res_i       (alu_res),
    .alu_res_valid_i (alu_res_valid),
    .ldu_req_i       (ldu_req_i),
    .ldu_wreq_i      (ldu_wreq_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .stu_operand_o   (stu_operand_o),
    .stu_valid_o     (stu_valid_o),
    .stu_ready_i     (stu_ready_i)
  );

  vector_regfile u_vrf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .wr_en_i   (wr_en),
    .wr_i      (wr)
  );

  lane_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (alu_req),
    .valid_i     (alu_valid),
    .res_o       (alu_res),
    .res_valid_o (alu_res_valid)
  );

endmodule

/* test/lane_assert.sv */
// Handshake assertions on the lane top, bound to every lane instance.
// All checks are off while rst_ni is low.

module lane_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                insn_valid_i,
  input logic                insn_ready_i,
  input logic                ldu_req_i,
  input logic                ldu_gnt_i,
  input lane_cfg_pkg::elem_t stu_operand_i,
  input logic                stu_valid_i,
  input logic                stu_ready_i,
  input logic                done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // Ready drops on acceptance and stays low until the done pulse
  insn_taken_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (insn_valid_i && insn_ready_i) |=> !insn_ready_i)
    else begin
      $error("insn_ready_o still high after acceptance");
      fail_cnt++;
    end

  insn_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!insn_ready_i && !done_i) |=> !insn_ready_i)
    else begin
      $error("insn_ready_o rose before done_o");
      fail_cnt++;
    end

  stu_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stu_valid_i && !stu_ready_i) |=> (stu_valid_i && $stable(stu_operand_i)))
    else begin
      $error("Store element changed while held");
      fail_cnt++;
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      $error("done_o high on two cycles in a row");
      fail_cnt++;
    end

  gnt_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_gnt_i |-> ldu_req_i)
    else begin
      $error("ldu_gnt_o high without ldu_req_i");
      fail_cnt++;
    end

endmodule

bind lane lane_assert u_lane_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .insn_valid_i  (insn_valid_i),
  .insn_ready_i  (insn_ready_o),
  .ldu_req_i     (ldu_req_i),
  .ldu_gnt_i     (ldu_gnt_o),
  .stu_operand_i (stu_operand_o),
  .stu_valid_i   (stu_valid_o),
  .stu_ready_i   (stu_ready_i),
  .done_i        (done_o)
);

/* test/tb_lane.sv */
// Trace-driven testbench for the vector lane.
// Records come from test/lane_trace.txt, opened relative to the project root.
// A cycle limit worked out from the trace ends a stuck run.

module tb_lane;
  timeunit 1ns;
  timeprecision 1ps;

  logic                     clk_i;
  logic                     rst_ni;
  lane_isa_pkg::lane_insn_t insn_i;
  logic                     insn_valid_i;
  logic                     insn_ready_o;
  logic                     ldu_req_i;
  lane_isa_pkg::vrf_wreq_t  ldu_wreq_i;
  logic                     ldu_gnt_o;
  lane_cfg_pkg::elem_t      stu_operand_o;
  logic                     stu_valid_o;
  logic                     stu_ready_i;
  logic                     done_o;
  lane_cfg_pkg::vid_t       done_id_o;

  string               lines [$];
  lane_cfg_pkg::elem_t got [$];
  int unsigned         cycle_cnt;
  int unsigned         cycle_limit = 1000;
  int                  n_tests;
  int                  n_failed;
  int                  n_checks;
  int                  n_errors;
  int                  test_checks;
  int                  test_errors;

  lane u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .ldu_req_i     (ldu_req_i),
    .ldu_wreq_i    (ldu_wreq_i),
    .ldu_gnt_o     (ldu_gnt_o),
    .stu_operand_o (stu_operand_o),
    .stu_valid_o   (stu_valid_o),
    .stu_ready_i   (stu_ready_i),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the trace", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    n_checks++;
    test_checks++;
    if (actual !== expected) begin
      $display("Error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      n_errors++;
      test_errors++;
    end
  endtask

  function automatic int split_record(input string line, output logic [7:0] kind,
                                      output logic [31:0] f [11]);
    return $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1], f[2],
                   f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
  endfunction

  // 20 cycles per element plus 200 per instruction
  function automatic int unsigned trace_cycle_limit();
    logic [7:0]  kind;
    logic [31:0] f [11];
    int unsigned limit;
    limit = 0;
    foreach (lines[i]) begin
      void'(split_record(lines[i], kind, f));
      if (kind == "L") limit += 20 * f[1];
      if (kind == "I") limit += 20 * f[4] + 200;
      if (kind == "S" || kind == "R") limit += 20 * f[1] + 200;
    end
    return limit + 100;
  endfunction

  function automatic string trim_eol(input string s);
    string r;
    r = s;
    while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" || r.getc(r.len() - 1) == "\r")) begin
      r = r.substr(0, r.len() - 2);
    end
    return r;
  endfunction

  task automatic load_word(input lane_cfg_pkg::vaddr_t addr, input lane_cfg_pkg::elem_t data);
    @(posedge clk_i);
    ldu_req_i        <= 1'b1;
    ldu_wreq_i.addr  <= addr;
    ldu_wreq_i.wdata <= data;
    do @(negedge clk_i); while (!ldu_gnt_o);
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
  endtask

  task automatic issue_insn(input lane_isa_pkg::lane_insn_t insn);
    @(posedge clk_i);
    insn_i       <= insn;
    insn_valid_i <= 1'b1;
    do @(negedge clk_i); while (!insn_ready_o);
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
  endtask

  task automatic wait_done(input lane_cfg_pkg::vid_t id);
    do @(negedge clk_i); while (!done_o);
    check_value(done_id_o, id, "done id");
  endtask

  // Collects streamed elements until done, optionally with random stalls
  task automatic stream_store(input lane_isa_pkg::lane_insn_t insn, input bit stalls);
    bit seen_done;
    seen_done = 1'b0;
    got.delete();
    issue_insn(insn);
    while (!seen_done) begin
      @(negedge clk_i);
      if (stu_valid_o && stu_ready_i) got.push_back(stu_operand_o);
      if (done_o) begin
        seen_done = 1'b1;
      end else begin
        @(posedge clk_i);
        if (stalls) stu_ready_i <= (($urandom % 4) != 0);
      end
    end
    check_value(done_id_o, insn.id, "store done id");
    @(posedge clk_i);
    stu_ready_i <= 1'b1;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_errors > 0) n_failed++;
    $display("Test %0d %s %s, %0d checks, %0d errors", n_tests, name,
             (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic run_record(input string line);
    logic [7:0]               kind;
    logic [31:0]              f [11];
    lane_isa_pkg::lane_insn_t insn;
    int                       k;
    void'(split_record(line, kind, f));
    insn = '0;
    case (kind)
      "L": begin
        for (k = 0; k < f[1] && k < 8; k++) begin
          load_word(lane_cfg_pkg::vaddr_t'(f[0] + k), f[2 + k]);
        end
      end
      "I": begin
        insn.op  = lane_isa_pkg::lane_op_e'(f[0][2:0]);
        insn.vd  = lane_cfg_pkg::vreg_t'(f[1]);
        insn.vs1 = lane_cfg_pkg::vreg_t'(f[2]);
        insn.vs2 = lane_cfg_pkg::vreg_t'(f[3]);
        insn.vl  = lane_cfg_pkg::vl_t'(f[4]);
        insn.id  = lane_cfg_pkg::vid_t'(f[5]);
        issue_insn(insn);
        wait_done(insn.id);
      end
      "S", "R": begin
        insn.op = lane_isa_pkg::VSTORE;
        insn.vd = lane_cfg_pkg::vreg_t'(f[0]);
        insn.vl = lane_cfg_pkg::vl_t'(f[1]);
        insn.id = lane_cfg_pkg::vid_t'(f[2]);
        stream_store(insn, kind == "R");
        check_value(got.size(), f[1], "store element count");
        for (k = 0; k < got.size() && k < f[1] && k < 8; k++) begin
          check_value(got[k], f[3 + k], $sformatf("v%0d element %0d", insn.vd, k));
        end
      end
      "E": end_test(trim_eol(line.substr(2, line.len() - 1)));
      default: begin
        $display("Trace line not understood: %s", trim_eol(line));
        n_errors++;
        test_errors++;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    string line;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    ldu_req_i    = 1'b0;
    ldu_wreq_i   = '0;
    stu_ready_i  = 1'b1;
    cycle_cnt    = 0;
    void'($urandom(32'hb9b7));
    fd = $fopen("test/lane_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file test/lane_trace.txt");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = trace_cycle_limit();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    foreach (lines[i]) begin
      run_record(lines[i]);
    end
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             n_tests, n_failed, n_checks, n_errors, u_dut.u_lane_assert.fail_cnt);
    if (n_errors == 0 && u_dut.u_lane_assert.fail_cnt == 0 && n_tests > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* test/lane_trace.txt */
# Fields in hex. L addr count data..: load words; I op vd vs1 vs2 vl id (op 0 add 1 sub 2 and 3 or 4 xor)
# S vd vl id e0..e7: store with expected elements, R the same under random stalls; E name ends a test

# Load then store
L 00 8 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
S 0 8 1 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
E load_store

# Each op on v2 and v1, VXOR with vl 5
L 08 8 00000001 00000002 00000003 00000004 0000000f 000000f0 ffffffff 80000000
L 10 8 00000010 00000001 00000003 ffffffff 000000ff 0000ff00 00000001 80000000
L 38 8 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
I 0 3 1 2 8 2
I 1 4 1 2 8 3
I 2 5 1 2 8 4
I 3 6 1 2 8 5
I 4 7 1 2 5 6
S 3 8 7 00000011 00000003 00000006 00000003 0000010e 0000fff0 00000000 00000000
S 4 8 8 0000000f ffffffff 00000000 fffffffb 000000f0 0000fe10 00000002 00000000
S 5 8 9 00000000 00000000 00000003 00000004 0000000f 00000000 00000001 80000000
S 6 8 a 00000011 00000003 00000003 ffffffff 000000ff 0000fff0 ffffffff 80000000
S 7 8 b 00000011 00000003 00000000 fffffffb 000000f0 a0000005 a0000006 a0000007
E arith_ops

# Chain: v0 = v3 - v4, v0 = v0 ^ v7, v1 = v0 + v0
I 1 0 4 3 8 c
I 4 0 7 0 8 d
I 0 1 0 0 8 e
S 0 8 f 00000013 00000007 00000006 fffffff3 000000ee a00001e5 5ffffff8 a0000007
S 1 8 0 00000026 0000000e 0000000c ffffffe6 000001dc 400003ca bffffff0 4000000e
E chained

# Stores under random stalls
R 0 8 1 00000013 00000007 00000006 fffffff3 000000ee a00001e5 5ffffff8 a0000007
R 1 8 2 00000026 0000000e 0000000c ffffffe6 000001dc 400003ca bffffff0 4000000e
E store_stall

# Zero length leaves v2 unchanged
I 0 2 1 0 0 9
S 2 8 a 00000010 00000001 00000003 ffffffff 000000ff 0000ff00 00000001 80000000
E zero_vl

/* flist.f */
common/lane_cfg_pkg.sv
common/lane_isa_pkg.sv
design/lane_alu.sv
lane/vector_regfile.sv
lane/lane_sequencer.sv
lane/operand_requester.sv
lane/lane.sv
test/lane_assert.sv
test/tb_lane.sv
